// ==== hdl/byteRam.sv ====
`default_nettype none

module byteRam #(
    parameter int depthLog2 = 10
) (
    input  logic             clk,
    input  memPkg::ramPort_t bus,
    output logic [7:0]       rdata
);
    import memPkg::*;

    logic [7:0] mem [2**depthLog2];
    logic [depthLog2-1:0] index;

    // only the low address bits select a byte
    assign index = bus.addr[depthLog2-1:0];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[index] <= bus.wdata;
        end
    end

    // registered read, data shows up one cycle later
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`default_nettype none

module fetchUnit #(
    parameter logic [memPkg::addrW-1:0] resetPc = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetchEn,
    input  logic                     redirect,
    input  logic [memPkg::addrW-1:0] redirectPc,
    output memPkg::memCmd_t          cmd,
    input  memPkg::memRsp_t          rsp,
    output logic                     instValid,
    output logic [memPkg::wordW-1:0] inst,
    output logic [memPkg::addrW-1:0] instPc
);
    import memPkg::*;

    logic [addrW-1:0] pc;
    logic             stale;

    always_comb begin
        cmd.en    = fetchEn;
        cmd.op    = memLoad;
        cmd.len   = lenWord;
        cmd.addr  = pc;
        cmd.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            stale     <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= rsp.done && !stale && !redirect;
            if (redirect) begin
                pc <= redirectPc;
                // an access may already be running for the old pc
                stale <= cmd.en && !rsp.done;
            end else if (rsp.done) begin
                stale <= 1'b0;
                if (!stale) begin
                    pc <= pc + addrW'(4);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            inst   <= rsp.rdata;
            instPc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dataValid,
    input  memPkg::dataReq_t         req,
    output logic                     dataBusy,
    output memPkg::memCmd_t          cmd,
    input  memPkg::memRsp_t          rsp,
    output logic                     loadDone,
    output logic                     storeDone,
    output logic [memPkg::wordW-1:0] loadData
);
    import memPkg::*;

    dataReq_t         reqQ;
    logic [wordW-1:0] extended;

    always_ff @(posedge clk) begin
        if (dataValid && !dataBusy) begin
            reqQ <= req;
        end
    end

    always_comb begin
        cmd.en    = dataBusy;
        cmd.op    = reqQ.op;
        cmd.len   = reqQ.len;
        cmd.addr  = reqQ.addr;
        cmd.wdata = reqQ.wdata;
    end

    // extend from the access length
    always_comb begin
        case (reqQ.len)
            lenByte: extended = {{24{reqQ.signExt && rsp.rdata[7]}}, rsp.rdata[7:0]};
            lenHalf: extended = {{16{reqQ.signExt && rsp.rdata[15]}}, rsp.rdata[15:0]};
            default: extended = rsp.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataBusy  <= 1'b0;
            loadDone  <= 1'b0;
            storeDone <= 1'b0;
        end else begin
            loadDone  <= rsp.done && (reqQ.op == memLoad);
            storeDone <= rsp.done && (reqQ.op == memStore);
            if (rsp.done) begin
                dataBusy <= 1'b0;
            end else if (dataValid) begin
                dataBusy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            loadData <= extended;
        end
    end

    // a new request must wait until the previous one has finished
    assert property (@(posedge clk) disable iff (rst)
        dataValid |-> !dataBusy);

endmodule

`default_nettype wire

// ==== hdl/memCtrl.sv ====
`default_nettype none

module memCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ioFull,
    input  memPkg::memCmd_t fetchCmd,
    input  memPkg::memCmd_t dataCmd,
    output memPkg::memRsp_t fetchRsp,
    output memPkg::memRsp_t dataRsp,
    output memPkg::ramPort_t ramBus,
    input  logic [7:0]      ramRdata
);
    import memPkg::*;

    ctrlState_t       state;
    logic [2:0]       stage;
    logic [addrW-1:0] addrQ;
    logic [wordW-1:0] wdataQ;
    accessLen_t       lenQ;
    logic [23:0]      assembly;

    logic             stall;
    logic             reading;
    logic             lastRead;
    logic             lastWrite;
    logic [2:0]       addrStage;
    logic [wordW-1:0] merged;

    assign stall = !rdy || ioFull;
    assign reading = (state == readInst) || (state == readData);

    // read ends one stage after the last address, write on the last address
    assign lastRead = (stage == lenQ);
    assign lastWrite = (stage + 3'd1 == lenQ);

    // while stalled the RAM keeps returning the byte already addressed
    assign addrStage = (stall && reading && stage != 3'd0) ? stage - 3'd1 : stage;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                idle: begin
                    stage <= '0;
                    // data side has priority
                    if (dataCmd.en) begin
                        state <= (dataCmd.op == memStore) ? writeData : readData;
                    end else if (fetchCmd.en) begin
                        state <= readInst;
                    end
                end
                readInst, readData: begin
                    if (lastRead) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                writeData: begin
                    if (lastWrite) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= idle;
                    stage <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == idle) begin
                if (dataCmd.en) begin
                    addrQ  <= dataCmd.addr;
                    lenQ   <= dataCmd.len;
                    wdataQ <= dataCmd.wdata;
                end else if (fetchCmd.en) begin
                    addrQ <= fetchCmd.addr;
                    lenQ  <= fetchCmd.len;
                end
            end else if (reading && stage != 3'd0 && !lastRead) begin
                // little endian, earliest byte ends up lowest
                assembly <= {ramRdata, assembly[23:8]};
            end
        end
    end

    // last byte comes straight from the RAM
    always_comb begin
        case (lenQ)
            lenByte: merged = {24'd0, ramRdata};
            lenHalf: merged = {16'd0, ramRdata, assembly[23:16]};
            default: merged = {ramRdata, assembly};
        endcase
    end

    always_comb begin
        ramBus.we    = (state == writeData) && !stall;
        ramBus.addr  = addrQ + addrW'(addrStage);
        ramBus.wdata = wdataQ[{stage[1:0], 3'b000} +: 8];
    end

    always_comb begin
        fetchRsp.done  = !stall && (state == readInst) && lastRead;
        fetchRsp.rdata = merged;
        dataRsp.done   = !stall && (((state == readData) && lastRead) ||
                                    ((state == writeData) && lastWrite));
        dataRsp.rdata  = merged;
    end

    // a running data access keeps its command until done
    assert property (@(posedge clk) disable iff (rst)
        (state == readData || state == writeData) && !dataRsp.done |=> $stable(dataCmd));

    // a write never goes past the bytes of its access
    assert property (@(posedge clk) disable iff (rst)
        ramBus.we |-> stage < lenQ);

    // a stall freezes the sequencer in place
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(state) && $stable(stage));

endmodule

`default_nettype wire

// ==== hdl/memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int addrW = 32;
    localparam int wordW = 32;

    typedef enum logic {
        memLoad,
        memStore
    } accessOp_t;

    // value is the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_t;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlState_t;

    typedef struct packed {
        accessOp_t        op;
        accessLen_t       len;
        logic             signExt;
        logic [addrW-1:0] addr;
        logic [wordW-1:0] wdata;
    } dataReq_t;

    // held by a requester until its done pulse
    typedef struct packed {
        logic             en;
        accessOp_t        op;
        accessLen_t       len;
        logic [addrW-1:0] addr;
        logic [wordW-1:0] wdata;
    } memCmd_t;

    typedef struct packed {
        logic             done;
        logic [wordW-1:0] rdata;
    } memRsp_t;

    typedef struct packed {
        logic             we;
        logic [addrW-1:0] addr;
        logic [7:0]       wdata;
    } ramPort_t;

endpackage

`default_nettype wire

// ==== hdl/memSystem.sv ====
`default_nettype none

module memSystem #(
    parameter logic [memPkg::addrW-1:0] resetPc = '0,
    parameter int depthLog2 = 10
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rdy,
    input  logic                     ioFull,
    input  logic                     fetchEn,
    input  logic                     redirect,
    input  logic [memPkg::addrW-1:0] redirectPc,
    output logic                     instValid,
    output logic [memPkg::wordW-1:0] inst,
    output logic [memPkg::addrW-1:0] instPc,
    input  logic                     dataValid,
    input  memPkg::dataReq_t         dataReq,
    output logic                     dataBusy,
    output logic                     loadDone,
    output logic                     storeDone,
    output logic [memPkg::wordW-1:0] loadData
);
    import memPkg::*;

    memCmd_t    fetchCmd;
    memCmd_t    dataCmd;
    memRsp_t    fetchRsp;
    memRsp_t    dataRsp;
    ramPort_t   ramBus;
    logic [7:0] ramRdata;

    fetchUnit #(
        .resetPc(resetPc)
    ) i_fetchUnit (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .cmd       (fetchCmd),
        .rsp       (fetchRsp),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk      (clk),
        .rst      (rst),
        .dataValid(dataValid),
        .req      (dataReq),
        .dataBusy (dataBusy),
        .cmd      (dataCmd),
        .rsp      (dataRsp),
        .loadDone (loadDone),
        .storeDone(storeDone),
        .loadData (loadData)
    );

    memCtrl i_memCtrl (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .ioFull  (ioFull),
        .fetchCmd(fetchCmd),
        .dataCmd (dataCmd),
        .fetchRsp(fetchRsp),
        .dataRsp (dataRsp),
        .ramBus  (ramBus),
        .ramRdata(ramRdata)
    );

    byteRam #(
        .depthLog2(depthLog2)
    ) i_byteRam (
        .clk  (clk),
        .bus  (ramBus),
        .rdata(ramRdata)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module memSystemTb -o memSystemTbSim

output=$(./obj_dir/memSystemTbSim)
echo "$output"

if grep -q "All tests passed!" <<< "$output"; then
    exit 0
fi
exit 1

// ==== test/memCases.txt ====
# kind len signExt addr wdata expected (addr, wdata and expected in hex)
# fetch: len is the word count, signExt keeps fetchEn high; stall: signExt turns stalls on
store 4 0 00000000 00000013 00000000
store 4 0 00000004 00a00093 00000000
store 4 0 00000008 00108113 00000000
store 4 0 0000000c 002081b3 00000000
store 4 0 00000010 fe000ee3 00000000
store 4 0 00000014 00000073 00000000
fetch 6 0 00000000 00000000 00000000
fetch 3 0 0000000c 00000000 00000000
store 1 0 00000200 000000a5 00000000
store 1 0 00000201 0000007f 00000000
store 2 0 00000202 000080c3 00000000
load 4 0 00000200 00000000 80c37fa5
load 1 1 00000200 00000000 ffffffa5
load 1 0 00000200 00000000 000000a5
load 2 1 00000202 00000000 ffff80c3
load 2 0 00000202 00000000 000080c3
load 2 1 00000200 00000000 00007fa5
fetch 2 1 00000004 00000000 00000000
store 4 0 00000204 deadbeef 00000000
load 4 0 00000204 00000000 deadbeef
load 2 0 00000206 00000000 0000dead
stall 0 1 00000000 00000000 00000000
store 4 0 00000208 13572468 00000000
store 2 0 0000020a 0000f00d 00000000
load 4 0 00000208 00000000 f00d2468
load 1 1 0000020b 00000000 fffffff0
load 2 1 00000208 00000000 00002468
load 1 0 00000205 00000000 000000be
stall 0 0 00000000 00000000 00000000
fetch 4 0 00000008 00000000 00000000

// ==== test/memSystemTb.sv ====
`default_nettype none

module memSystemTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        rdy = 1'b1;
    logic        ioFull = 1'b0;
    logic        fetchEn;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        instValid;
    logic [31:0] inst;
    logic [31:0] instPc;
    logic        dataValid;
    dataReq_t    dataReq;
    logic        dataBusy;
    logic        loadDone;
    logic        storeDone;
    logic [31:0] loadData;

    // reference model of the RAM contents
    logic [7:0]  shadow [1024];
    bit          known [1024];
    logic [31:0] nextPc = '0;
    int          instCount = 0;
    int          doneCount = 0;
    int          accessCount = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    integer      seed = 32'ha95c38d1;
    logic [31:0] stallRand;
    bit          stallOn = 1'b0;

    memSystem #(
        .resetPc  (32'h0),
        .depthLog2(10)
    ) i_memSystem (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc),
        .dataValid (dataValid),
        .dataReq   (dataReq),
        .dataBusy  (dataBusy),
        .loadDone  (loadDone),
        .storeDone (storeDone),
        .loadData  (loadData)
    );

    always #4 clk = ~clk;

    // random back-pressure windows
    always @(posedge clk) begin
        stallRand = $random(seed);
        if (stallOn) begin
            ioFull <= (stallRand[1:0] == 2'd0);
            rdy    <= (stallRand[4:2] != 3'd0);
        end else begin
            ioFull <= 1'b0;
            rdy    <= 1'b1;
        end
    end

    function automatic logic [31:0] shadowWord(input logic [31:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = shadow[addr[9:0] + 10'(k)];
        end
        return w;
    endfunction

    function automatic bit wordKnown(input logic [31:0] addr);
        bit all;
        all = 1'b1;
        for (int k = 0; k < 4; k++) begin
            all = all && known[addr[9:0] + 10'(k)];
        end
        return all;
    endfunction

    task automatic checkLow(input string name, input logic value);
        checks++;
        assert (value == 1'b0) else begin
            errors++;
            $display("error at %0t: %s expected 0 got %b", $time, name, value);
        end
    endtask

    // instruction stream must stay in order
    always @(negedge clk) begin
        if (!rst && instValid) begin
            checks++;
            assert (instPc == nextPc) else begin
                errors++;
                $display("error at %0t: instPc expected %h got %h", $time, nextPc, instPc);
            end
            if (wordKnown(instPc)) begin
                assert (inst == shadowWord(instPc)) else begin
                    errors++;
                    $display("error at %0t: inst expected %h got %h",
                             $time, shadowWord(instPc), inst);
                end
            end
            nextPc = nextPc + 32'd4;
            instCount++;
        end
    end

    // each data access ends in exactly one done pulse
    always @(negedge clk) begin
        if (!rst && (loadDone || storeDone)) begin
            doneCount++;
        end
    end

    task automatic waitInsts(input int count);
        int target;
        int t;
        for (int w = 1; w <= count; w++) begin
            target = instCount + 1;
            t = 0;
            while (instCount < target && t < 200) begin
                @(negedge clk);
                t++;
            end
            if (instCount < target) begin
                timeouts++;
                $display("timeout at %0t: no instruction arrived", $time);
                return;
            end
        end
    endtask

    task automatic runFetch(input int count, input bit keepOn, input logic [31:0] addr);
        @(posedge clk);
        fetchEn <= 1'b1;
        @(posedge clk);
        redirect   <= 1'b1;
        redirectPc <= addr;
        @(posedge clk);
        redirect <= 1'b0;
        nextPc = addr;
        waitInsts(count);
        if (!keepOn) begin
            @(posedge clk);
            fetchEn <= 1'b0;
        end
    endtask

    task automatic runData(input bit isStore, input int len, input logic sx,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] expected);
        int t;
        bit seen;
        accessCount++;
        @(posedge clk);
        dataValid       <= 1'b1;
        dataReq.op      <= isStore ? memStore : memLoad;
        dataReq.len     <= accessLen_t'(len[2:0]);
        dataReq.signExt <= sx;
        dataReq.addr    <= addr;
        dataReq.wdata   <= wdata;
        @(posedge clk);
        dataValid <= 1'b0;
        t = 0;
        seen = 1'b0;
        while (!seen && t < 200) begin
            @(negedge clk);
            seen = isStore ? storeDone : loadDone;
            t++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t: access to %h never completed", $time, addr);
        end else if (isStore) begin
            for (int k = 0; k < len; k++) begin
                shadow[addr[9:0] + 10'(k)] = wdata[8*k +: 8];
                known[addr[9:0] + 10'(k)] = 1'b1;
            end
        end else begin
            checks++;
            assert (loadData == expected) else begin
                errors++;
                $display("error at %0t: loadData expected %h got %h", $time, expected, loadData);
            end
        end
    endtask

    initial begin
        int fd;
        string line;
        string kind;
        int len;
        int sx;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        rst = 1'b1;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        dataValid = 1'b0;
        dataReq = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkLow("instValid", instValid);
        checkLow("loadDone", loadDone);
        checkLow("storeDone", storeDone);
        checkLow("dataBusy", dataBusy);
        // first fetch from the reset pc
        @(posedge clk);
        fetchEn <= 1'b1;
        waitInsts(1);
        @(posedge clk);
        fetchEn <= 1'b0;

        fd = $fopen("test/memCases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the cases file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                if ($sscanf(line, "%s %d %d %h %h %h", kind, len, sx, addr, wdata,
                            expected) != 6) begin
                    continue;
                end
                if (kind == "store") begin
                    runData(1'b1, len, sx[0], addr, wdata, expected);
                end else if (kind == "load") begin
                    runData(1'b0, len, sx[0], addr, wdata, expected);
                end else if (kind == "fetch") begin
                    runFetch(len, sx[0], addr);
                end else if (kind == "stall") begin
                    stallOn = sx[0];
                end
            end
            $fclose(fd);
        end
        repeat (20) @(posedge clk);
        checks++;
        assert (doneCount == accessCount) else begin
            errors++;
            $display("error at %0t: done pulses expected %0d got %0d",
                     $time, accessCount, doneCount);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/memPkg.sv
hdl/byteRam.sv
hdl/memCtrl.sv
hdl/fetchUnit.sv
hdl/loadStoreUnit.sv
hdl/memSystem.sv
test/memSystemTb.sv
